/* filelist.f */
tetris_pkg.sv
board_if.sv
fall_timer.sv
collision_check.sv
saved_blocks.sv
piece_fsm.sv
tetris_core.sv
tetris_properties.sv
tetris_tb.sv

/* tetris_tb.sv */
`timescale 1ns/1ps

module tetris_tb;

    localparam int FT = 40;
    localparam int COLS = tetris_pkg::BOARD_COLS;
    localparam int ROWS = tetris_pkg::BOARD_ROWS;
    localparam int NONE = 0, LEFT = 1, RIGHT = 2, DOWN = 3, ROT = 4, TICK = 5;

    logic clk = 1'b0;
    logic reset, move_left, move_right, move_down, rotate, ready, game_over;
    tetris_pkg::kind_t  piece_kind;
    tetris_pkg::board_t board;
    tetris_pkg::coord_t piece_x, piece_y;
    tetris_pkg::mask_t  piece_mask;
    logic [15:0]        lines_cleared;

    tetris_core #(.FALL_TICKS(FT)) dut0 (
        .clk(clk), .reset(reset), .piece_kind(piece_kind), .move_left(move_left),
        .move_right(move_right), .move_down(move_down), .rotate(rotate), .ready(ready),
        .game_over(game_over), .board(board), .piece_x(piece_x), .piece_y(piece_y),
        .piece_mask(piece_mask), .lines_cleared(lines_cleared)
    );

    always #2 clk = ~clk;

    // ##############################
    // reference model state
    // ##############################

    tetris_pkg::board_t m_board;
    tetris_pkg::kind_t  m_kind, next_kind, default_kind;
    int m_x, m_y, m_rot, m_lines, m_cnt, pieces, errors, pending;
    int assert_fails;
    logic m_over, need_check, random_mode;
    logic [31:0] rng = 32'h1d78;
    string test_name;
    int script[$];
    int q_kind[$], q_left[$], q_right[$], q_rot[$];   // per-piece directed moves

    function automatic int next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return int'(rng & 32'h7fff_ffff);
    endfunction

    function automatic logic hits(tetris_pkg::board_t b, int x, int y, tetris_pkg::mask_t m);
        int cx;
        int cy;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
            begin
                cx = x + c;
                cy = y + r;
                if (m[r*4 + c] && (cx < 0 || cx >= COLS || cy < 0 || cy >= ROWS))
                    return 1'b1;
                if (m[r*4 + c] && b[cy*COLS + cx])
                    return 1'b1;
            end
        return 1'b0;
    endfunction

    function automatic void load_piece();
        next_kind = default_kind;
        if (q_kind.size() > 0)
        begin
            next_kind = q_kind.pop_front();
            repeat (q_left.pop_front()) script.push_back(LEFT);
            repeat (q_right.pop_front()) script.push_back(RIGHT);
            repeat (q_rot.pop_front()) script.push_back(ROT);
        end
        else if (random_mode)
            next_kind = next_random() % 7;
    endfunction

    function automatic void model_spawn();
        m_kind = next_kind;
        m_x = 3;
        m_y = 0;
        m_rot = 0;
        m_cnt = 0;
        pieces++;
        m_over = hits(m_board, m_x, m_y, tetris_pkg::piece_shape(m_kind, 2'd0));
    endfunction

    function automatic void model_step(input int act);
        int nx;
        int ny;
        int nr;
        int r;
        tetris_pkg::mask_t m;
        nx = m_x + (act == RIGHT) - (act == LEFT);
        ny = m_y + (act == DOWN || act == TICK);
        nr = (m_rot + (act == ROT)) % 4;
        m_cnt = (act == TICK) ? 0 : m_cnt + 1;
        if (!hits(m_board, nx, ny, tetris_pkg::piece_shape(m_kind, 2'(nr))))
        begin
            if (ny != m_y)
                m_cnt = 0;                          // timer restarts on a drop
            m_x = nx;
            m_y = ny;
            m_rot = nr;
        end
        else if (ny != m_y)
        begin
            m = tetris_pkg::piece_shape(m_kind, 2'(m_rot));
            for (int i = 0; i < 16; i++)
                if (m[i] && m_x + i % 4 >= 0 && m_x + i % 4 < COLS && m_y + i / 4 < ROWS)
                    m_board[(m_y + i / 4)*COLS + m_x + i % 4] = 1'b1;
            r = ROWS - 1;
            while (r >= 0)
            begin
                if (&m_board[r*COLS +: COLS])
                begin
                    for (int k = r; k > 0; k--)
                        m_board[k*COLS +: COLS] = m_board[(k-1)*COLS +: COLS];
                    m_board[0 +: COLS] = '0;
                    m_lines++;
                end
                else
                    r--;
            end
            load_piece();
            model_spawn();
        end
    endfunction

    function automatic int choose_cmd();
        int r;
        if (script.size() > 0)
            return script.pop_front();
        if (!random_mode)
            return NONE;
        r = next_random() % 8;
        return (r < 4) ? r + 1 : NONE;
    endfunction

    // ##############################
    // checking
    // ##############################

    task automatic check_value(input string name, input logic [239:0] exp,
                               input logic [239:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic compare_all();
        check_value("board", m_board, board);
        check_value("lines", 240'(m_lines), 240'(lines_cleared));
        check_value("piece_x", 240'(6'(m_x)), 240'(6'(piece_x)));
        check_value("piece_y", 240'(6'(m_y)), 240'(6'(piece_y)));
        check_value("mask", 240'(tetris_pkg::piece_shape(m_kind, 2'(m_rot))), 240'(piece_mask));
        check_value("game_over", 240'(m_over), 240'(game_over));
    endtask

    // sample at negedge then drive at posedge
    task automatic cycle_step();
        int next;
        next = NONE;
        @(negedge clk);
        if (need_check && (ready || game_over))
        begin
            compare_all();
            need_check = 1'b0;
        end
        if (ready && !m_over)
        begin
            if (m_cnt == FT - 1 || pending != NONE)
            begin
                model_step((m_cnt == FT - 1) ? TICK : pending);   // tick wins
                need_check = 1'b1;
            end
            else
            begin
                m_cnt++;
                next = choose_cmd();
            end
        end
        @(posedge clk);
        move_left  <= (next == LEFT);
        move_right <= (next == RIGHT);
        move_down  <= (next == DOWN);
        rotate     <= (next == ROT);
        piece_kind <= next_kind;
        pending = next;
    endtask

    task automatic run_pieces(input int n);
        int target;
        target = pieces + n;
        while (pieces < target && !m_over)
            cycle_step();
        while (need_check)
            cycle_step();
    endtask

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b1;
        {move_left, move_right, move_down, rotate} <= 4'b0;
        pending = NONE;
        need_check = 1'b0;
        m_board = '0;
        m_lines = 0;
        script.delete();
        load_piece();
        piece_kind <= next_kind;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset board", '0, board);
        check_value("reset lines", '0, 240'(lines_cleared));
        model_spawn();
        need_check = 1'b1;
    endtask

    task automatic add_piece(input int kind, input int left, input int right, input int rot);
        q_kind.push_back(kind);
        q_left.push_back(left);
        q_right.push_back(right);
        q_rot.push_back(rot);
    endtask

    initial
    begin
        {reset, move_left, move_right, move_down, rotate} = 5'b10000;
        piece_kind = 3'd0;
        errors = 0;
        pieces = 0;
        random_mode = 1'b0;
        default_kind = 3'd1;                        // O when nothing is queued
        test_name = "moves";
        add_piece(2, 6, 0, 0);                      // T pushed into the left wall
        add_piece(2, 0, 9, 0);
        add_piece(0, 0, 0, 1);
        add_piece(6, 2, 0, 3);
        reset_dut();
        run_pieces(4);
        test_name = "rows";
        add_piece(0, 3, 0, 0);
        add_piece(0, 3, 0, 0);
        add_piece(0, 0, 3, 0);
        add_piece(0, 0, 3, 0);
        add_piece(1, 0, 0, 0);                      // double clear
        add_piece(0, 3, 0, 0);
        add_piece(0, 0, 3, 0);
        add_piece(1, 0, 0, 0);                      // single clear
        reset_dut();
        run_pieces(8);
        check_value("total lines", 240'(3), 240'(lines_cleared));
        test_name = "random";
        random_mode = 1'b1;
        reset_dut();
        run_pieces(40);
        test_name = "game_over";
        random_mode = 1'b0;
        reset_dut();
        run_pieces(30);
        check_value("over reached", 240'(1), 240'(game_over));
        repeat (20)
        begin
            @(negedge clk);
            check_value("ready low", '0, 240'(ready));
            check_value("board held", m_board, board);
        end
        assert_fails = dut0.fsm0.fsm_props.fail_count + dut0.store0.store_props.fail_count;
        $display("checks done, %0d errors and %0d assertion failures over %0d pieces",
                 errors, assert_fails, pieces);
        if (errors == 0 && assert_fails == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(200 * (24 * FT + 300) * 4);
        $display("watchdog: the run timed out before all tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

/* tetris_properties.sv */
`timescale 1ns/1ps

module tetris_properties #(
    parameter bit FSM_SIDE = 1'b1
) (
    input logic        clk,
    input logic        reset,
    input logic        save,
    input logic        ready,
    input logic        clearing,
    input logic        game_over,
    input logic [15:0] lines
);

    int fail_count = 0;

    if (FSM_SIDE)
    begin : fsm_checks
        no_ready_in_clear: assert property (@(posedge clk) disable iff (reset)
            !(ready && clearing))
        else
        begin
            $error("ready high while a row is full");
            fail_count++;
        end

        over_sticks: assert property (@(posedge clk) disable iff (reset)
            game_over |=> game_over)
        else
        begin
            $error("game_over dropped without reset");
            fail_count++;
        end
    end
    else
    begin : store_checks
        save_one_cycle: assert property (@(posedge clk) disable iff (reset)
            save |=> !save)
        else
        begin
            $error("save held longer than one cycle");
            fail_count++;
        end

        lines_rise: assert property (@(posedge clk) disable iff (reset)
            !$past(reset) |-> lines >= $past(lines))
        else
        begin
            $error("line count went down");
            fail_count++;
        end
    end

endmodule

bind piece_fsm tetris_properties #(.FSM_SIDE(1'b1)) fsm_props (
    .clk(clk), .reset(reset), .save(1'b0), .ready(ready),
    .clearing(bus.clearing), .game_over(game_over), .lines(16'd0)
);

bind saved_blocks tetris_properties #(.FSM_SIDE(1'b0)) store_props (
    .clk(clk), .reset(reset), .save(bus.save), .ready(1'b0),
    .clearing(bus.clearing), .game_over(1'b0), .lines(lines_cleared)
);

/* tetris_core.sv */
`timescale 1ns/1ps

module tetris_core #(
    parameter int FALL_TICKS = 50
) (
    input  logic               clk,
    input  logic               reset,
    input  tetris_pkg::kind_t  piece_kind,
    input  logic               move_left,
    input  logic               move_right,
    input  logic               move_down,
    input  logic               rotate,
    output logic               ready,
    output logic               game_over,
    output tetris_pkg::board_t board,
    output tetris_pkg::coord_t piece_x,
    output tetris_pkg::coord_t piece_y,
    output tetris_pkg::mask_t  piece_mask,
    output logic [15:0]        lines_cleared
);

    board_if bif ();

    logic               tick;
    logic               collide;
    logic               run;
    logic               restart;
    tetris_pkg::coord_t cand_x;
    tetris_pkg::coord_t cand_y;
    tetris_pkg::mask_t  cand_mask;

    piece_fsm fsm0 (
        .clk        (clk),
        .reset      (reset),
        .piece_kind (piece_kind),
        .move_left  (move_left),
        .move_right (move_right),
        .move_down  (move_down),
        .rotate     (rotate),
        .tick       (tick),
        .collide    (collide),
        .cand_x     (cand_x),
        .cand_y     (cand_y),
        .cand_mask  (cand_mask),
        .run        (run),
        .restart    (restart),
        .ready      (ready),
        .game_over  (game_over),
        .bus        (bif.ctrl)
    );

    fall_timer #(.FALL_TICKS(FALL_TICKS)) timer0 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .restart (restart),
        .tick    (tick)
    );

    collision_check check0 (
        .board     (bif.board),
        .cand_x    (cand_x),
        .cand_y    (cand_y),
        .cand_mask (cand_mask),
        .collide   (collide)
    );

    saved_blocks store0 (
        .clk           (clk),
        .reset         (reset),
        .bus           (bif.store),
        .lines_cleared (lines_cleared)
    );

    assign board      = bif.board;
    assign piece_x    = bif.piece_x;
    assign piece_y    = bif.piece_y;
    assign piece_mask = bif.piece_mask;

endmodule

/* piece_fsm.sv */
`timescale 1ns/1ps

module piece_fsm (
    input  logic               clk,
    input  logic               reset,
    input  tetris_pkg::kind_t  piece_kind,
    input  logic               move_left,
    input  logic               move_right,
    input  logic               move_down,
    input  logic               rotate,
    input  logic               tick,
    input  logic               collide,
    output tetris_pkg::coord_t cand_x,
    output tetris_pkg::coord_t cand_y,
    output tetris_pkg::mask_t  cand_mask,
    output logic               run,
    output logic               restart,
    output logic               ready,
    output logic               game_over,
    board_if.ctrl              bus
);

    tetris_pkg::fsm_state_t state;
    tetris_pkg::fsm_state_t next_state;

    tetris_pkg::kind_t  kind;
    tetris_pkg::rot_t   rot;
    tetris_pkg::coord_t pos_x;
    tetris_pkg::coord_t pos_y;

    tetris_pkg::rot_t   try_rot;             // registered candidate
    tetris_pkg::coord_t try_x;
    tetris_pkg::coord_t try_y;
    logic               try_down;

    logic any_cmd;

    assign any_cmd = tick | rotate | move_left | move_right | move_down;

    // ##############################
    // next state
    // ##############################

    always_comb
    begin
        next_state = state;
        case (state)
            tetris_pkg::IDLE:  next_state = tetris_pkg::SPAWN;
            tetris_pkg::SPAWN: next_state = collide ? tetris_pkg::OVER : tetris_pkg::WAIT;
            tetris_pkg::WAIT:  if (any_cmd) next_state = tetris_pkg::TRY;
            tetris_pkg::TRY:
            begin
                if (collide && try_down)
                    next_state = tetris_pkg::LOCK;   // landed
                else
                    next_state = tetris_pkg::WAIT;
            end
            tetris_pkg::LOCK:  next_state = tetris_pkg::CLEAR;
            tetris_pkg::CLEAR: if (!bus.clearing) next_state = tetris_pkg::SPAWN;
            tetris_pkg::OVER:  next_state = tetris_pkg::OVER;
            default:           next_state = tetris_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= tetris_pkg::IDLE;
            kind  <= 3'd0;
            rot   <= 2'd0;
            pos_x <= 6'sd0;
            pos_y <= 6'sd0;
        end
        else
        begin
            state <= next_state;
            if (state == tetris_pkg::SPAWN)
            begin
                kind  <= piece_kind;
                rot   <= 2'd0;
                pos_x <= tetris_pkg::SPAWN_X;
                pos_y <= tetris_pkg::SPAWN_Y;
            end
            else if (state == tetris_pkg::TRY && !collide)
            begin
                pos_x <= try_x;                  // commit
                pos_y <= try_y;
                rot   <= try_rot;
            end
        end
    end

    // candidate from the chosen command, tick first
    always_ff @(posedge clk)
    begin
        if (state == tetris_pkg::WAIT)
        begin
            try_x    <= pos_x;
            try_y    <= pos_y;
            try_rot  <= rot;
            try_down <= 1'b0;
            if (tick || (!rotate && !move_left && !move_right && move_down))
            begin
                try_y    <= pos_y + 6'sd1;
                try_down <= 1'b1;
            end
            else if (rotate)
                try_rot <= rot + 2'd1;
            else if (move_left)
                try_x <= pos_x - 6'sd1;
            else if (move_right)
                try_x <= pos_x + 6'sd1;
        end
    end

    // ##############################
    // outputs
    // ##############################

    always_comb
    begin
        if (state == tetris_pkg::SPAWN)
        begin
            cand_x    = tetris_pkg::SPAWN_X;
            cand_y    = tetris_pkg::SPAWN_Y;
            cand_mask = tetris_pkg::piece_shape(piece_kind, 2'd0);
        end
        else
        begin
            cand_x    = try_x;
            cand_y    = try_y;
            cand_mask = tetris_pkg::piece_shape(kind, try_rot);
        end
    end

    assign run       = (state == tetris_pkg::WAIT);
    assign ready     = (state == tetris_pkg::WAIT);
    assign game_over = (state == tetris_pkg::OVER);
    assign restart   = (state == tetris_pkg::SPAWN) ||
                       (state == tetris_pkg::TRY && try_down && !collide);

    assign bus.piece_x    = pos_x;
    assign bus.piece_y    = pos_y;
    assign bus.piece_mask = tetris_pkg::piece_shape(kind, rot);
    assign bus.save       = (state == tetris_pkg::LOCK);

endmodule

/* saved_blocks.sv */
`timescale 1ns/1ps

module saved_blocks (
    input  logic        clk,
    input  logic        reset,
    board_if.store      bus,
    output logic [15:0] lines_cleared
);

    localparam int COLS = tetris_pkg::BOARD_COLS;
    localparam int ROWS = tetris_pkg::BOARD_ROWS;

    tetris_pkg::board_t board_q;
    tetris_pkg::board_t merged;
    tetris_pkg::board_t shifted;
    logic [ROWS-1:0]    row_full;
    logic [4:0]         low_row;

    // ##############################
    // full rows
    // ##############################

    always_comb
    begin
        low_row = 5'd0;
        for (int r = 0; r < ROWS; r++)
        begin
            row_full[r] = &board_q[r*COLS +: COLS];
            if (row_full[r])
                low_row = 5'(r);                  // last hit is the lowest row
        end
    end

    assign bus.clearing = |row_full;
    assign bus.board    = board_q;

    // rows above the removed one drop by one, row 0 refills empty
    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            if (r > int'(low_row))
                shifted[r*COLS +: COLS] = board_q[r*COLS +: COLS];
            else if (r == 0)
                shifted[r*COLS +: COLS] = '0;
            else
                shifted[r*COLS +: COLS] = board_q[(r-1)*COLS +: COLS];
        end
    end

    // ##############################
    // merge of the locked piece
    // ##############################

    always_comb
    begin
        int cx;
        int cy;
        merged = board_q;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                cx = int'(bus.piece_x) + c;
                cy = int'(bus.piece_y) + r;
                if (bus.piece_mask[r*4 + c] && cx >= 0 && cx < COLS && cy >= 0 && cy < ROWS)
                    merged[cy*COLS + cx] = 1'b1;  // off-board cells dropped
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            board_q       <= '0;
            lines_cleared <= 16'd0;
        end
        else if (bus.save)
        begin
            board_q <= merged;
        end
        else if (bus.clearing)
        begin
            board_q       <= shifted;             // one row per cycle
            lines_cleared <= lines_cleared + 16'd1;
        end
    end

endmodule

/* collision_check.sv */
`timescale 1ns/1ps

module collision_check (
    input  tetris_pkg::board_t board,
    input  tetris_pkg::coord_t cand_x,
    input  tetris_pkg::coord_t cand_y,
    input  tetris_pkg::mask_t  cand_mask,
    output logic               collide
);

    always_comb
    begin
        int cx;
        int cy;
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                cx = int'(cand_x) + c;                 // signed, may go below 0
                cy = int'(cand_y) + r;
                if (cand_mask[r*4 + c])
                begin
                    if (cx < 0 || cx >= tetris_pkg::BOARD_COLS)
                    begin
                        hit = 1'b1;                    // side walls
                    end
                    else if (cy < 0 || cy >= tetris_pkg::BOARD_ROWS)
                    begin
                        hit = 1'b1;                    // floor
                    end
                    else if (board[cy*tetris_pkg::BOARD_COLS + cx])
                    begin
                        hit = 1'b1;                    // stack
                    end
                end
            end
        end
        collide = hit;
    end

endmodule

/* fall_timer.sv */
`timescale 1ns/1ps

module fall_timer #(
    parameter int FALL_TICKS = 50
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic restart,
    output logic tick
);

    localparam int CW = $clog2(FALL_TICKS + 1);

    logic [CW-1:0] count;

    assign tick = run && (count == CW'(FALL_TICKS - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (restart)
        begin
            count <= '0;                        // spawn or committed drop
        end
        else if (run)
        begin
            if (tick)
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

endmodule

/* board_if.sv */
`timescale 1ns/1ps

interface board_if;

    tetris_pkg::coord_t piece_x;      // committed placement
    tetris_pkg::coord_t piece_y;
    tetris_pkg::mask_t  piece_mask;
    logic               save;         // lock strobe
    tetris_pkg::board_t board;
    logic               clearing;     // some row still full

    modport ctrl (
        output piece_x,
        output piece_y,
        output piece_mask,
        output save,
        input  board,
        input  clearing
    );

    modport store (
        input  piece_x,
        input  piece_y,
        input  piece_mask,
        input  save,
        output board,
        output clearing
    );

endinterface

/* tetris_pkg.sv */
package tetris_pkg;

    // ##############################
    // board geometry
    // ##############################

    localparam int BOARD_COLS = 10;
    localparam int BOARD_ROWS = 24;

    typedef logic [BOARD_COLS*BOARD_ROWS-1:0] board_t;   // row-major, row 0 on top
    typedef logic [15:0]                      mask_t;    // bit r*4+c
    typedef logic signed [5:0]                coord_t;
    typedef logic [2:0]                       kind_t;    // I O T S Z J L
    typedef logic [1:0]                       rot_t;

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        WAIT,
        TRY,
        LOCK,
        CLEAR,
        OVER
    } fsm_state_t;

    localparam coord_t SPAWN_X = 6'sd3;
    localparam coord_t SPAWN_Y = 6'sd0;

    // ##############################
    // piece shapes
    // ##############################

    // one nibble per mask row, row 0 in the low nibble, col 0 in the lsb
    localparam mask_t SHAPES [0:6][0:3] = '{
        '{16'h00f0, 16'h4444, 16'h0f00, 16'h2222},   // I
        '{16'h0066, 16'h0066, 16'h0066, 16'h0066},   // O
        '{16'h0072, 16'h0262, 16'h0270, 16'h0232},   // T
        '{16'h0036, 16'h0462, 16'h0360, 16'h0231},   // S
        '{16'h0063, 16'h0264, 16'h0630, 16'h0132},   // Z
        '{16'h0071, 16'h0226, 16'h0470, 16'h0322},   // J
        '{16'h0074, 16'h0622, 16'h0170, 16'h0223}    // L
    };

    function automatic mask_t piece_shape(input kind_t kind, input rot_t rot);
        kind_t k;
        k = (kind == 3'd7) ? 3'd0 : kind;                // 7 falls back to I
        return SHAPES[k][rot];
    endfunction

endpackage
